//--- source/cpu_pkg.sv
// ============================
// shared types and encodings of the cpu core
// instruction word: op[11:8] size[7:6] dst[5:3] src[2:0]
// OP_ST stores the register named by the dst field
// ============================
package cpu_pkg;

    typedef logic [31:0] word_t;     // register contents, din, wdata, operands
    typedef logic [11:0] ins_t;
    typedef logic [3:0]  op_t;
    typedef logic [1:0]  size_t;
    typedef logic [2:0]  rsel_t;     // 0-3 banked accumulators, 4-7 shared pointers

    localparam op_t OP_LDI   = 4'd0;
    localparam op_t OP_LDR   = 4'd1;
    localparam op_t OP_ADD   = 4'd2;
    localparam op_t OP_SUB   = 4'd3;
    localparam op_t OP_AND   = 4'd4;
    localparam op_t OP_OR    = 4'd5;
    localparam op_t OP_XOR   = 4'd6;
    localparam op_t OP_EXF   = 4'd7;
    localparam op_t OP_LDRFP = 4'd8;  // bank select from din
    localparam op_t OP_ST    = 4'd9;
    localparam op_t OP_STF   = 4'd10; // store status word

    localparam size_t SZ_BYTE = 2'd0;
    localparam size_t SZ_WORD = 2'd1;
    localparam size_t SZ_LONG = 2'd2;

    // microcode selectors
    typedef logic [1:0] ral_sel_t;
    typedef logic [1:0] opnd_sel_t;
    typedef logic [1:0] ld_sel_t;
    typedef logic [2:0] cc_sel_t;
    typedef logic [1:0] rmux_sel_t;

    localparam ral_sel_t  RAL_NONE  = 2'd0;
    localparam ral_sel_t  RAL_SRC   = 2'd1;
    localparam ral_sel_t  RAL_DST   = 2'd2;

    localparam opnd_sel_t OPND_NONE = 2'd0;
    localparam opnd_sel_t OPND_LD0  = 2'd1;  // reads the dst register
    localparam opnd_sel_t OPND_LD1  = 2'd2;  // reads the src register

    localparam ld_sel_t   LD_NONE   = 2'd0;
    localparam ld_sel_t   LD_DST    = 2'd1;
    localparam ld_sel_t   LD_RFP    = 2'd2;

    localparam cc_sel_t   CC_NONE     = 3'd0;
    localparam cc_sel_t   CC_ARITH_N0 = 3'd1;
    localparam cc_sel_t   CC_ARITH_N1 = 3'd2;
    localparam cc_sel_t   CC_LOGIC_H1 = 3'd3;
    localparam cc_sel_t   CC_LOGIC_H0 = 3'd4;

    localparam rmux_sel_t RMUX_REG  = 2'd0;
    localparam rmux_sel_t RMUX_DIN  = 2'd1;
    localparam rmux_sel_t RMUX_SR   = 2'd2;

    typedef enum logic [2:0] {
        SEQ_IDLE  = 3'd0,
        SEQ_STEP1 = 3'd1,
        SEQ_STEP2 = 3'd2,
        SEQ_STEP3 = 3'd3,
        SEQ_STEP4 = 3'd4
    } seq_state_t;

endpackage

//--- source/cpu_alu.sv
// ============================
// combinational, flags judged at the operand size
// v is parity of the low byte for logic operations
// ============================
`timescale 1ns/1ps

module cpu_alu (
    input  cpu_pkg::op_t   op,
    input  cpu_pkg::size_t size,
    input  cpu_pkg::word_t op0,
    input  cpu_pkg::word_t op1,
    output cpu_pkg::word_t rslt,
    output logic           si,
    output logic           zi,
    output logic           hi,
    output logic           vi,
    output logic           ci
);
    import cpu_pkg::*;

    logic [32:0] arith;
    logic [32:0] cv;        // carry or borrow into each bit
    logic        ov;
    logic        logic_op;

    always_comb begin
        if (op == OP_SUB) begin
            arith = {1'b0, op0} - {1'b0, op1};
        end else begin
            arith = {1'b0, op0} + {1'b0, op1};
        end
        cv = arith ^ {1'b0, op0} ^ {1'b0, op1};
        logic_op = (op == OP_AND) || (op == OP_OR) || (op == OP_XOR);
        case (op)
            OP_ADD, OP_SUB: rslt = arith[31:0];
            OP_AND:         rslt = op0 & op1;
            OP_OR:          rslt = op0 | op1;
            OP_XOR:         rslt = op0 ^ op1;
            default:        rslt = op1;         // loads pass op1
        endcase
        case (size)
            SZ_BYTE: begin
                si = rslt[7];
                zi = (rslt[7:0] == 8'd0);
                ci = cv[8];
                ov = cv[7] ^ cv[8];
            end
            SZ_WORD: begin
                si = rslt[15];
                zi = (rslt[15:0] == 16'd0);
                ci = cv[16];
                ov = cv[15] ^ cv[16];
            end
            default: begin
                si = rslt[31];
                zi = (rslt == 32'd0);
                ci = cv[32];
                ov = cv[31] ^ cv[32];
            end
        endcase
        hi = cv[4];
        vi = logic_op ? ~^rslt[7:0] : ov;   // even parity
    end

endmodule

//--- source/cpu_seq.sv
// ============================
// start is taken only while idle and cen is high
// done and wr are low whenever cen is low
// ============================
`timescale 1ns/1ps

module cpu_seq (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               start,
    input  cpu_pkg::ins_t      ins,
    output cpu_pkg::op_t       op,
    output cpu_pkg::size_t     size,
    output cpu_pkg::rsel_t     dst_r,
    output cpu_pkg::rsel_t     src_r,
    output cpu_pkg::ral_sel_t  ral_sel,
    output cpu_pkg::opnd_sel_t opnd_sel,
    output cpu_pkg::rmux_sel_t rmux_sel,
    output cpu_pkg::ld_sel_t   ld_sel,
    output cpu_pkg::cc_sel_t   cc_sel,
    output logic               exff,
    output logic               busy,
    output logic               done,
    output logic               wr
);
    import cpu_pkg::*;

    seq_state_t state;
    ins_t       ins_q;
    logic       last;
    cc_sel_t    alu_cc;

    assign op    = ins_q[11:8];
    assign size  = ins_q[7:6];
    assign dst_r = ins_q[5:3];
    assign src_r = ins_q[2:0];

    assign busy = (state != SEQ_IDLE);
    assign done = cen & busy & last;
    assign wr   = done & ((op == OP_ST) || (op == OP_STF));

    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: last = (state == SEQ_STEP4);
            OP_LDR, OP_ST:                         last = (state == SEQ_STEP3);
            OP_LDI, OP_STF:                        last = (state == SEQ_STEP2);
            default:                               last = (state == SEQ_STEP1);
        endcase
        case (op)
            OP_ADD:  alu_cc = CC_ARITH_N0;
            OP_SUB:  alu_cc = CC_ARITH_N1;
            OP_AND:  alu_cc = CC_LOGIC_H1;
            default: alu_cc = CC_LOGIC_H0;
        endcase
    end

    // microcode, one pattern per step
    always_comb begin
        ral_sel  = RAL_NONE;
        opnd_sel = OPND_NONE;
        rmux_sel = RMUX_REG;
        ld_sel   = LD_NONE;
        cc_sel   = CC_NONE;
        exff     = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                case (state)
                    SEQ_STEP1: ral_sel = RAL_DST;
                    SEQ_STEP2: begin
                        ral_sel  = RAL_SRC;
                        opnd_sel = OPND_LD0;
                    end
                    SEQ_STEP3: opnd_sel = OPND_LD1;
                    SEQ_STEP4: begin
                        ld_sel = LD_DST;
                        cc_sel = alu_cc;
                    end
                    default: ;
                endcase
            end
            OP_LDR: begin
                case (state)
                    SEQ_STEP1: ral_sel = RAL_SRC;
                    SEQ_STEP2: begin
                        ral_sel  = RAL_DST;     // dst taken alongside the operand
                        opnd_sel = OPND_LD1;
                    end
                    SEQ_STEP3: ld_sel = LD_DST;
                    default: ;
                endcase
            end
            OP_LDI: begin
                if (state == SEQ_STEP1) begin
                    ral_sel  = RAL_DST;
                    opnd_sel = OPND_LD1;
                    rmux_sel = RMUX_DIN;
                end else if (state == SEQ_STEP2) begin
                    ld_sel = LD_DST;
                end
            end
            OP_ST: begin
                if (state == SEQ_STEP1) begin
                    ral_sel = RAL_DST;
                end else if (state == SEQ_STEP2) begin
                    opnd_sel = OPND_LD0;
                end
            end
            OP_STF: begin
                if (state == SEQ_STEP1) begin
                    opnd_sel = OPND_LD0;
                    rmux_sel = RMUX_SR;
                end
            end
            OP_EXF:   exff   = (state == SEQ_STEP1);
            OP_LDRFP: ld_sel = (state == SEQ_STEP1) ? LD_RFP : LD_NONE;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SEQ_IDLE;
            ins_q <= '0;
        end else if (cen) begin
            if (state == SEQ_IDLE) begin
                if (start) begin
                    state <= SEQ_STEP1;
                    ins_q <= ins;
                end
            end else if (last) begin
                state <= SEQ_IDLE;
            end else begin
                state <= seq_state_t'(state + 3'd1);
            end
        end
    end

endmodule

//--- source/cpu_regs.sv
// ============================
// BANKS must be 2 or 4
// operands load at full width, size applies on write-back
// status word: bit 15 set, rfp in 13:12, flags in 7:0
// ============================
`timescale 1ns/1ps

module cpu_regs #(
    parameter int BANKS = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  cpu_pkg::size_t     size,
    input  cpu_pkg::rsel_t     dst_r,
    input  cpu_pkg::rsel_t     src_r,
    input  cpu_pkg::ral_sel_t  ral_sel,
    input  cpu_pkg::opnd_sel_t opnd_sel,
    input  cpu_pkg::rmux_sel_t rmux_sel,
    input  cpu_pkg::ld_sel_t   ld_sel,
    input  cpu_pkg::cc_sel_t   cc_sel,
    input  logic               exff,
    input  cpu_pkg::word_t     din,
    input  cpu_pkg::word_t     rslt,
    input  logic               si,
    input  logic               zi,
    input  logic               hi,
    input  logic               vi,
    input  logic               ci,
    output cpu_pkg::word_t     op0,
    output cpu_pkg::word_t     op1
);
    import cpu_pkg::*;

    localparam int RFP_W  = $clog2(BANKS);
    localparam int CODE_W = RFP_W + 3;      // {ptr, bank, index}

    word_t              accs [BANKS*4];
    word_t              ptrs [4];
    logic [5:0]         fmain;              // s z h v n c
    logic [5:0]         falt;
    logic [RFP_W-1:0]   rfp;
    logic [CODE_W-1:0]  src;
    logic [CODE_W-1:0]  dst;
    logic [CODE_W-1:0]  rd_code;
    word_t              rd_val;
    word_t              dst_val;
    word_t              wb_val;
    word_t              rmux;
    logic [15:0]        sr;

    // full register code, pointers ignore the bank
    function automatic logic [CODE_W-1:0] reg_code(input rsel_t r);
        logic [RFP_W-1:0] bank;
        bank = r[2] ? '0 : rfp;
        reg_code = {r[2], bank, r[1:0]};
    endfunction

    function automatic word_t reg_read(input logic [CODE_W-1:0] code);
        if (code[CODE_W-1]) begin
            reg_read = ptrs[code[1:0]];
        end else begin
            reg_read = accs[code[CODE_W-2:0]];
        end
    endfunction

    assign sr = {1'b1, 1'b0, 2'(rfp), 4'd0,
                 fmain[5], fmain[4], 1'b0, fmain[3], 1'b0, fmain[2], fmain[1], fmain[0]};

    always_comb begin
        rd_code = (opnd_sel == OPND_LD0) ? dst : src;
        rd_val  = reg_read(rd_code);
        dst_val = reg_read(dst);
        case (rmux_sel)
            RMUX_DIN: rmux = din;
            RMUX_SR:  rmux = {16'd0, sr};
            default:  rmux = rd_val;
        endcase
        case (size)
            SZ_BYTE: wb_val = {dst_val[31:8], rslt[7:0]};   // upper bits kept
            SZ_WORD: wb_val = {dst_val[31:16], rslt[15:0]};
            default: wb_val = rslt;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BANKS*4; i++) begin
                accs[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                ptrs[i] <= '0;
            end
            fmain <= '0;
            falt  <= '0;
            rfp   <= '0;
            src   <= '0;
            dst   <= '0;
            op0   <= '0;
            op1   <= '0;
        end else if (cen) begin
            if (exff) begin
                {fmain, falt} <= {falt, fmain};
            end
            case (cc_sel)
                CC_ARITH_N0: fmain <= {si, zi, hi, vi, 1'b0, ci};
                CC_ARITH_N1: fmain <= {si, zi, hi, vi, 1'b1, ci};
                CC_LOGIC_H1: fmain <= {si, zi, 1'b1, vi, 1'b0, 1'b0}; // v is parity here
                CC_LOGIC_H0: fmain <= {si, zi, 1'b0, vi, 1'b0, 1'b0};
                default: ;
            endcase
            case (ral_sel)
                RAL_SRC: src <= reg_code(src_r);
                RAL_DST: dst <= reg_code(dst_r);
                default: ;
            endcase
            case (opnd_sel)
                OPND_LD0: op0 <= rmux;
                OPND_LD1: op1 <= rmux;
                default: ;
            endcase
            case (ld_sel)
                LD_DST: begin
                    if (dst[CODE_W-1]) begin
                        ptrs[dst[1:0]] <= wb_val;
                    end else begin
                        accs[dst[CODE_W-2:0]] <= wb_val;
                    end
                end
                LD_RFP: rfp <= din[RFP_W-1:0];    // din modulo BANKS
                default: ;
            endcase
        end
    end

endmodule

//--- source/cpu_core.sv
// ============================
// register and datapath core, BANKS is 2 or 4
// wdata is op0, valid while wr is high
// ============================
`timescale 1ns/1ps

module cpu_core #(
    parameter int BANKS = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  logic           start,
    input  cpu_pkg::ins_t  ins,
    input  cpu_pkg::word_t din,
    output logic           busy,
    output logic           done,
    output logic           wr,
    output cpu_pkg::word_t wdata
);
    import cpu_pkg::*;

    op_t       op;
    size_t     size;
    rsel_t     dst_r;
    rsel_t     src_r;
    ral_sel_t  ral_sel;
    opnd_sel_t opnd_sel;
    rmux_sel_t rmux_sel;
    ld_sel_t   ld_sel;
    cc_sel_t   cc_sel;
    logic      exff;
    word_t     op1;
    word_t     rslt;
    logic      si;
    logic      zi;
    logic      hi;
    logic      vi;
    logic      ci;

    cpu_seq seq_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .start    (start),
        .ins      (ins),
        .op       (op),
        .size     (size),
        .dst_r    (dst_r),
        .src_r    (src_r),
        .ral_sel  (ral_sel),
        .opnd_sel (opnd_sel),
        .rmux_sel (rmux_sel),
        .ld_sel   (ld_sel),
        .cc_sel   (cc_sel),
        .exff     (exff),
        .busy     (busy),
        .done     (done),
        .wr       (wr)
    );

    cpu_regs #(
        .BANKS (BANKS)
    ) regs_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .size     (size),
        .dst_r    (dst_r),
        .src_r    (src_r),
        .ral_sel  (ral_sel),
        .opnd_sel (opnd_sel),
        .rmux_sel (rmux_sel),
        .ld_sel   (ld_sel),
        .cc_sel   (cc_sel),
        .exff     (exff),
        .din      (din),
        .rslt     (rslt),
        .si       (si),
        .zi       (zi),
        .hi       (hi),
        .vi       (vi),
        .ci       (ci),
        .op0      (wdata),      // store path
        .op1      (op1)
    );

    cpu_alu alu_i (
        .op   (op),
        .size (size),
        .op0  (wdata),
        .op1  (op1),
        .rslt (rslt),
        .si   (si),
        .zi   (zi),
        .hi   (hi),
        .vi   (vi),
        .ci   (ci)
    );

endmodule

//--- bench/cpu_core_chk.sv
// ============================
// bound into cpu_core, sampled on the rising clock
// fail_count is read by the testbench
// ============================
`timescale 1ns/1ps

module cpu_core_chk (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic wr
);
    int fail_count = 0;

    wr_with_done: assert property (@(posedge clk) disable iff (rst) wr |-> done)
        else begin
            fail_count++;
            $error("wr high without done");
        end

    done_with_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else begin
            fail_count++;
            $error("done high without busy");
        end

    quiet_in_reset: assert property (@(posedge clk) rst |-> !busy && !done && !wr)
        else begin
            fail_count++;
            $error("strobe high during reset");
        end

    single_done: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_count++;
            $error("done high on two cycles in a row");
        end

endmodule

bind cpu_core cpu_core_chk chk_i (
    .clk  (clk),
    .rst  (rst),
    .busy (busy),
    .done (done),
    .wr   (wr)
);

//--- bench/cpu_core_tb.sv
// ============================
// directed and random instructions, BANKS fixed at 4
// expected stores come from a model of the register rules
// assertion failures in the bound checker end the run as well
// ============================
`timescale 1ns/1ps

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int BANKS   = 4;
    localparam int NREG    = BANKS * 4 + 4;
    localparam int SLOT_W  = $clog2(NREG);
    localparam int N_RAND  = 400;
    localparam int T_LIMIT = 64;        // cycles allowed per wait

    logic  clk;
    logic  rst;
    logic  cen;
    logic  start;
    ins_t  ins;
    word_t din;
    logic  busy;
    logic  done;
    logic  wr;
    word_t wdata;

    integer     seed;
    int         accepted;
    int         done_count;
    word_t      exp_mem [1024];         // expected store values in issue order
    logic [9:0] put_idx;
    logic [9:0] get_idx;
    word_t      m_regs [NREG];          // accumulators of all banks, then pointers
    logic [5:0] m_flags;                // s z h v n c
    logic [5:0] m_alt;
    logic [1:0] m_rfp;

    cpu_core #(
        .BANKS (BANKS)
    ) cpu_core_i (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .start (start),
        .ins   (ins),
        .din   (din),
        .busy  (busy),
        .done  (done),
        .wr    (wr),
        .wdata (wdata)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic cen_draw();
        cen_draw = ($unsigned($random(seed)) % 4) != 0;     // high about 3 of 4
    endfunction

    // cen cycles from the accepting edge up to done
    function automatic int step_total(input op_t op);
        case (op)
            OP_LDR, OP_ST:    step_total = 3;
            OP_LDI, OP_STF:   step_total = 2;
            OP_EXF, OP_LDRFP: step_total = 1;
            default:          step_total = 4;   // add, sub and the logic ops
        endcase
    endfunction

    function automatic logic [SLOT_W-1:0] reg_slot(input rsel_t r);
        if (r[2]) begin
            reg_slot = SLOT_W'(BANKS * 4 + int'(r[1:0]));    // shared pointers
        end else begin
            reg_slot = SLOT_W'(int'(m_rfp) * 4 + int'(r[1:0]));
        end
    endfunction

    // applies one instruction to the model, returns the store value
    function automatic word_t model_step(input ins_t i, input word_t d);
        op_t               op;
        int                w;
        logic [SLOT_W-1:0] rd;
        word_t             mask;
        word_t             a;
        word_t             b;
        word_t             r;
        logic [32:0]       full;
        logic              sa;
        logic              sb;
        logic              sr;
        logic              h;
        logic              v;
        logic              c;
        op   = i[11:8];
        w    = (i[7:6] == SZ_BYTE) ? 8 : (i[7:6] == SZ_WORD) ? 16 : 32;
        mask = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
        rd   = reg_slot(i[5:3]);
        a    = m_regs[rd] & mask;
        b    = m_regs[reg_slot(i[2:0])] & mask;
        sa   = 1'(a >> (w - 1));
        sb   = 1'(b >> (w - 1));
        model_step = '0;
        case (op)
            OP_LDI, OP_LDR: begin
                r = (op == OP_LDI) ? (d & mask) : b;
                m_regs[rd] = (m_regs[rd] & ~mask) | r;
            end
            OP_ADD, OP_SUB: begin
                if (op == OP_ADD) begin
                    full = {1'b0, a} + {1'b0, b};
                    c    = 1'(full >> w);
                    h    = ((a & 32'hf) + (b & 32'hf)) > 32'hf;
                end else begin
                    full = {1'b0, a} - {1'b0, b};
                    c    = a < b;                               // borrow
                    h    = (a & 32'hf) < (b & 32'hf);
                end
                r  = full[31:0] & mask;
                sr = 1'(r >> (w - 1));
                v  = (op == OP_ADD) ? ((sa == sb) && (sr != sa)) : ((sa != sb) && (sr != sa));
                m_regs[rd] = (m_regs[rd] & ~mask) | r;
                m_flags = {sr, r == 0, h, v, op == OP_SUB, c};
            end
            OP_AND, OP_OR, OP_XOR: begin
                r = (op == OP_AND) ? (a & b) : (op == OP_OR) ? (a | b) : (a ^ b);
                m_regs[rd] = (m_regs[rd] & ~mask) | r;
                v = ($countones(r[7:0]) % 2) == 0;             // even parity
                m_flags = {1'(r >> (w - 1)), r == 0, op == OP_AND, v, 2'b00};
            end
            OP_EXF:   {m_flags, m_alt} = {m_alt, m_flags};
            OP_LDRFP: m_rfp = 2'(d % BANKS);
            OP_ST:    model_step = m_regs[rd];
            OP_STF: begin
                model_step = {16'd0, 2'b10, m_rfp, 4'd0, m_flags[5:4], 1'b0,
                              m_flags[3], 1'b0, m_flags[2:0]};
            end
            default: ;
        endcase
    endfunction

    task automatic issue(input op_t op, input size_t sz, input rsel_t rd, input rsel_t rs,
                         input word_t d);
        int    n;
        int    steps;
        ins_t  i;
        word_t exp;
        i = {op, sz, rd, rs};
        n = 0;
        @(negedge clk);
        start = 1'b1;
        ins   = i;
        din   = d;
        cen   = cen_draw();
        @(posedge clk);
        check_value("busy", word_t'(busy), 32'd0);      // idle after the last done
        while (!cen) begin
            n++;
            if (n > T_LIMIT) begin
                abort_run("timeout: start was never accepted");
            end
            @(negedge clk);
            cen = cen_draw();
            @(posedge clk);
            check_value("busy", word_t'(busy), 32'd0);
        end
        accepted++;
        exp = model_step(i, d);
        if (op == OP_ST || op == OP_STF) begin
            exp_mem[put_idx] = exp;
            put_idx = put_idx + 10'd1;
        end
        n     = 0;
        steps = 0;
        do begin
            @(negedge clk);
            cen   = cen_draw();
            start = 1'($random(seed));      // ignored while busy
            ins   = 12'($random(seed));
            @(posedge clk);
            check_value("busy", word_t'(busy), 32'd1);
            if (cen) begin
                steps++;
            end
            n++;
            if (n > T_LIMIT) begin
                abort_run("timeout: no done after an accepted start");
            end
        end while (!done);
        check_value("done step", word_t'(steps), word_t'(step_total(op)));
    endtask

    task automatic store_reg(input rsel_t r);
        issue(OP_ST, SZ_LONG, r, 3'd0, 32'd0);
    endtask

    task automatic store_flags();
        issue(OP_STF, SZ_LONG, 3'd0, 3'd0, 32'd0);
    endtask

    task automatic random_ins();
        int  k;
        op_t op;
        k  = $unsigned($random(seed)) % 14;
        op = (k > 12) ? OP_STF : (k > 10) ? OP_ST : k[3:0];    // stores weighted up
        issue(op, 2'($unsigned($random(seed)) % 3), 3'($random(seed)), 3'($random(seed)),
              $random(seed));
    endtask

    always @(posedge clk) begin : compare
        if (!rst) begin
            if (cpu_core_i.chk_i.fail_count != 0) begin
                abort_run("a strobe assertion in the checker failed");
            end
            if (done) begin
                done_count++;
            end
            if (wr) begin
                if (get_idx == put_idx) begin
                    abort_run("wr pulse with no store pending");
                end
                check_value("wdata", wdata, exp_mem[get_idx]);
                get_idx <= get_idx + 10'd1;
            end
        end
    end

    initial begin
        seed       = 32'h9041_a5d7;
        clk        = 1'b0;
        rst        = 1'b1;
        cen        = 1'b0;
        start      = 1'b0;
        ins        = '0;
        din        = '0;
        accepted   = 0;
        done_count = 0;
        put_idx    = '0;
        get_idx    = '0;
        m_regs     = '{default: '0};
        m_flags    = '0;
        m_alt      = '0;
        m_rfp      = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // loads at each size, upper bits kept
        issue(OP_LDI, SZ_LONG, 3'd1, 3'd0, 32'h1234_5678);
        store_reg(3'd1);
        issue(OP_LDI, SZ_WORD, 3'd1, 3'd0, 32'hdead_beef);
        store_reg(3'd1);
        issue(OP_LDI, SZ_BYTE, 3'd1, 3'd0, 32'hffff_ffa5);
        store_reg(3'd1);
        issue(OP_LDR, SZ_LONG, 3'd6, 3'd1, 32'd0);
        store_reg(3'd6);

        issue(OP_LDI, SZ_LONG, 3'd2, 3'd0, 32'h7fff_8f80);
        for (int s = 0; s < 3; s++) begin
            issue(OP_ADD, 2'(s), 3'd2, 3'd1, 32'd0);
            store_reg(3'd2);
            store_flags();
            issue(OP_SUB, 2'(s), 3'd1, 3'd2, 32'd0);
            store_reg(3'd1);
            store_flags();
        end

        issue(OP_LDI, SZ_LONG, 3'd4, 3'd0, 32'h0f0f_3c5a);
        for (int k = 0; k < 3; k++) begin
            issue(OP_AND + 4'(k), SZ_WORD, 3'd4, 3'd2, 32'd0);
            store_reg(3'd4);
            store_flags();
        end

        // bank 2 accumulators against shared pointers
        issue(OP_LDRFP, SZ_LONG, 3'd0, 3'd0, 32'd6);
        issue(OP_LDI, SZ_LONG, 3'd0, 3'd0, 32'haaaa_5555);
        issue(OP_LDI, SZ_LONG, 3'd5, 3'd0, 32'h0bad_cafe);
        store_flags();
        issue(OP_LDRFP, SZ_LONG, 3'd0, 3'd0, 32'd0);
        store_reg(3'd0);
        store_reg(3'd5);

        store_flags();
        issue(OP_EXF, SZ_LONG, 3'd0, 3'd0, 32'd0);
        store_flags();
        issue(OP_EXF, SZ_LONG, 3'd0, 3'd0, 32'd0);
        store_flags();

        for (int k = 0; k < N_RAND; k++) begin
            random_ins();
        end

        @(negedge clk);
        start = 1'b0;
        cen   = 1'b1;
        repeat (8) @(posedge clk);
        check_value("done count", word_t'(done_count), word_t'(accepted));
        check_value("stores seen", word_t'(get_idx), word_t'(put_idx));
        $display("test passed");
        $finish;
    end

endmodule

//--- vlog.f
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_seq.sv
source/cpu_regs.sv
source/cpu_core.sv
bench/cpu_core_chk.sv
bench/cpu_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs cpu_core_tb with Verilator
# passes only when the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_core_tb -f vlog.f -o cpu_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/cpu_core_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
